// ==== vlog.f ====
+incdir+include
verilog/filter_pkg.sv
verilog/filter_regs.sv
verilog/pixel_window.sv
verilog/edge_scaler.sv
verilog/diff_map.sv
verilog/output_stage.sv
verilog/scaler_filter_top.sv
test/tb_filter.sv

// ==== run.sh ====
#!/bin/sh
# compile the filter and its testbench with verilator, then run the simulation
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f vlog.f --top-module tb_filter -o tb_filter
./obj_dir/tb_filter

// ==== test/tb_filter.sv ====
// testbench for the scan-converter filter with register, pass, scale and diff-map tests
`timescale 1ns/1ps
`include "filter_settings.svh"

module tb_filter;

    localparam int LATENCY    = 5;
    localparam int WAIT_LIMIT = 50;

    typedef struct packed {
        logic [31:0]       due;
        logic [`PIX_W-1:0] data;
        logic [3:0]        sync;
        logic [2:0]        line_id;
        logic [2:0]        col_id;
    } exp_entry_t;

    logic                  pclk_act;
    logic                  reset_n;
    filter_pkg::pixel_t    prev_i, curr_i, next_i;
    logic [2:0]            col_i, row_i;
    logic                  hsync_i, vsync_i, de_i, mask_en_i;
    logic [2:0]            line_id_i, col_id_i;
    filter_pkg::pixel_t    data_o;
    logic                  hsync_o, vsync_o, de_o, mask_en_o;
    logic [2:0]            line_id_o, col_id_o;
    logic                  wb_cyc_i, wb_stb_i, wb_we_i;
    logic [`WB_ADDR_W-1:0] wb_adr_i;
    logic [`WB_DATA_W-1:0] wb_dat_i, wb_dat_o;
    logic                  wb_ack_o;

    integer            seed;
    logic [31:0]       cyc = '0;
    exp_entry_t        exp_q [$];
    exp_entry_t        cur_exp;
    // centre pixel as the DUT history should hold it
    logic [`PIX_W-1:0] center_m1 = '0;
    logic [`PIX_W-1:0] win_pix [0:8];
    logic [`PIX_W-1:0] exp_pix [0:8];

    scaler_filter_top dut_i (.*);

    initial pclk_act = 1'b0;
    always #5 pclk_act = ~pclk_act;

    always @(posedge pclk_act) begin
        cyc <= cyc + 1;
    end

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    // outputs are checked on the falling edge, away from register updates
    always @(negedge pclk_act) begin
        if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
            cur_exp = exp_q.pop_front();
            check_value("data_o", 32'(data_o.raw), 32'(cur_exp.data));
            check_value("syncs and enables", 32'({hsync_o, vsync_o, de_o, mask_en_o}),
                        32'(cur_exp.sync));
            check_value("line_id_o", 32'(line_id_o), 32'(cur_exp.line_id));
            check_value("col_id_o", 32'(col_id_o), 32'(cur_exp.col_id));
        end
    end

    function automatic logic [`PIX_W-1:0] rand_pix();
        logic [31:0] r;
        r = $random(seed);
        return r[`PIX_W-1:0];
    endfunction

    // per-channel sum of halves
    function automatic logic [`PIX_W-1:0] halves_sum(input logic [`PIX_W-1:0] a,
                                                     input logic [`PIX_W-1:0] b);
        logic [`PIX_W-1:0] s;
        for (int i = 0; i < 3; i++) begin
            s[i*`CH_W +: `CH_W] = (a[i*`CH_W +: `CH_W] >> 1) + (b[i*`CH_W +: `CH_W] >> 1);
        end
        return s;
    endfunction

    // one sub-pixel sample with random side signals
    task automatic drive_sample(input logic [`PIX_W-1:0] p, input logic [`PIX_W-1:0] c,
                                input logic [`PIX_W-1:0] n, input logic [2:0] row,
                                input logic [2:0] col, input logic check,
                                input logic [`PIX_W-1:0] exp_data);
        logic [31:0] r;
        exp_entry_t  ent;
        @(negedge pclk_act);
        r = $random(seed);
        prev_i.raw = p;
        curr_i.raw = c;
        next_i.raw = n;
        row_i = row;
        col_i = col;
        {hsync_i, vsync_i, de_i, mask_en_i} = r[3:0];
        line_id_i = r[6:4];
        col_id_i = r[9:7];
        if (check) begin
            ent.due = cyc + LATENCY;
            ent.data = exp_data;
            ent.sync = r[3:0];
            ent.line_id = r[6:4];
            ent.col_id = r[9:7];
            exp_q.push_back(ent);
        end
        // history advances on the last copy of a source pixel
        if (col == 3'd2) begin
            center_m1 = c;
        end
    endtask

    task automatic idle_video();
        @(negedge pclk_act);
        col_i = 3'd0;
        de_i = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        idle_video();
        n = 0;
        while (exp_q.size() > 0 && n < WAIT_LIMIT) begin
            @(negedge pclk_act);
            n++;
        end
        if (exp_q.size() > 0) begin
            $display("timeout: expected video outputs never arrived");
            abort_run();
        end
    endtask

    task automatic wb_access(input logic we, input logic [`WB_ADDR_W-1:0] adr,
                             input logic [`WB_DATA_W-1:0] wdat,
                             output logic [`WB_DATA_W-1:0] rdat);
        int n;
        @(negedge pclk_act);
        check_value("wb_ack_o before access", 32'(wb_ack_o), 32'd0);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i = we;
        wb_adr_i = adr;
        wb_dat_i = wdat;
        n = 0;
        do begin
            @(negedge pclk_act);
            n++;
        end while (!wb_ack_o && n < WAIT_LIMIT);
        if (!wb_ack_o) begin
            $display("timeout: no Wishbone acknowledge from the register block");
            abort_run();
        end
        rdat = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i = 1'b0;
        @(negedge pclk_act);
        check_value("wb_ack_o after access", 32'(wb_ack_o), 32'd0);
    endtask

    task automatic write_reg(input int adr, input int val);
        logic [`WB_DATA_W-1:0] rd;
        wb_access(1'b1, `WB_ADDR_W'(adr), `WB_DATA_W'(val), rd);
    endtask

    task automatic read_expect(input int adr, input int exp);
        logic [`WB_DATA_W-1:0] rd;
        wb_access(1'b0, `WB_ADDR_W'(adr), '0, rd);
        check_value("register read", 32'(rd), exp);
    endtask

    // three source pixels per line, the last one completes the window
    task automatic feed_window();
        for (int r = 0; r < 3; r++) begin
            for (int k = 0; k < 3; k++) begin
                for (int c = 0; c < 3; c++) begin
                    drive_sample(win_pix[k], win_pix[3+k], win_pix[6+k], 3'(r), 3'(c),
                                 k == 2, exp_pix[r*3+c]);
                end
            end
        end
        wait_drain();
    endtask

    task automatic test_registers();
        read_expect(`REG_MODE, 0);
        read_expect(`REG_STRENGTH, 0);
        write_reg(`REG_MODE, `MODE_DIFF);
        read_expect(`REG_MODE, `MODE_DIFF);
        // upper bits are dropped
        write_reg(`REG_STRENGTH, 'hFD);
        read_expect(`REG_STRENGTH, 5);
        // low bits differ from both stored values
        write_reg(2, 'hFE);
        read_expect(2, 0);
        read_expect(`REG_MODE, `MODE_DIFF);
        read_expect(`REG_STRENGTH, 5);
        write_reg(`REG_STRENGTH, 0);
        write_reg(`REG_MODE, `MODE_PASS);
    endtask

    task automatic test_pass(input int mode);
        write_reg(`REG_MODE, mode);
        for (int i = 0; i < 60; i++) begin
            drive_sample(rand_pix(), rand_pix(), rand_pix(), 3'(rand_pix()), 3'(i % 3),
                         1'b1, center_m1);
        end
        wait_drain();
    endtask

    task automatic test_scale_flat();
        logic [`PIX_W-1:0] p;
        write_reg(`REG_MODE, `MODE_SCALE);
        write_reg(`REG_STRENGTH, 3);
        p = rand_pix();
        for (int k = 0; k < 9; k++) begin
            win_pix[k] = p;
            exp_pix[k] = p;
        end
        feed_window();
    endtask

    task automatic test_scale_corner();
        // B and D alike, C and G equal to E, everything else far apart
        win_pix = '{24'h60E020, 24'h102030, 24'hC08040,
                    24'h102030, 24'hC08040, 24'h40C0A0,
                    24'hC08040, 24'hA040C0, 24'hE06080};
        for (int k = 0; k < 9; k++) begin
            exp_pix[k] = win_pix[`WIN_E];
        end
        write_reg(`REG_MODE, `MODE_SCALE);
        write_reg(`REG_STRENGTH, 7);
        exp_pix[0] = win_pix[`WIN_D];
        feed_window();
        write_reg(`REG_STRENGTH, 3);
        exp_pix[0] = halves_sum(win_pix[`WIN_E], win_pix[`WIN_D]);
        feed_window();
    endtask

    task automatic test_diff();
        logic [`PIX_W-1:0] p;
        write_reg(`REG_MODE, `MODE_DIFF);
        p = rand_pix();
        for (int k = 0; k < 9; k++) begin
            win_pix[k] = p;
            exp_pix[k] = `COLOR_SAME;
        end
        feed_window();
        // one white neighbour on black at each position around the centre
        for (int pos = 0; pos < 9; pos++) begin
            if (pos != `WIN_E) begin
                for (int k = 0; k < 9; k++) begin
                    win_pix[k] = (k == pos) ? 24'hFFFFFF : 24'h000000;
                    exp_pix[k] = (k == pos) ? `COLOR_DIFF : `COLOR_SAME;
                end
                feed_window();
            end
        end
    endtask

    initial begin
        seed = 63;
        reset_n = 1'b0;
        prev_i = '0;
        curr_i = '0;
        next_i = '0;
        col_i = '0;
        row_i = '0;
        hsync_i = 1'b0;
        vsync_i = 1'b0;
        de_i = 1'b0;
        mask_en_i = 1'b0;
        line_id_i = '0;
        col_id_i = '0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        repeat (5) @(posedge pclk_act);
        @(negedge pclk_act);
        reset_n = 1'b1;
        check_value("data_o after reset", 32'(data_o.raw), 32'd0);
        check_value("de_o after reset", 32'(de_o), 32'd0);

        test_registers();
        test_pass(`MODE_PASS);
        // code 2 has no filter and falls back to pass
        test_pass(2);
        test_scale_flat();
        test_scale_corner();
        test_diff();

        $display("TEST OK");
        $finish;
    end

endmodule

// ==== verilog/scaler_filter_top.sv ====
// scan-converter pixel filter top level with register block and datapath
`timescale 1ns/1ps
`include "filter_settings.svh"

module scaler_filter_top (
    input  logic                  pclk_act,
    input  logic                  reset_n,
    input  filter_pkg::pixel_t    prev_i,
    input  filter_pkg::pixel_t    curr_i,
    input  filter_pkg::pixel_t    next_i,
    input  logic [2:0]            col_i,
    input  logic [2:0]            row_i,
    input  logic                  hsync_i,
    input  logic                  vsync_i,
    input  logic                  de_i,
    input  logic                  mask_en_i,
    input  logic [2:0]            line_id_i,
    input  logic [2:0]            col_id_i,
    output filter_pkg::pixel_t    data_o,
    output logic                  hsync_o,
    output logic                  vsync_o,
    output logic                  de_o,
    output logic                  mask_en_o,
    output logic [2:0]            line_id_o,
    output logic [2:0]            col_id_o,
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  logic [`WB_ADDR_W-1:0] wb_adr_i,
    input  logic [`WB_DATA_W-1:0] wb_dat_i,
    output logic [`WB_DATA_W-1:0] wb_dat_o,
    output logic                  wb_ack_o
);

    logic [1:0]         mode;
    logic [2:0]         strength;
    filter_pkg::pixel_t window [0:8];
    filter_pkg::pixel_t sub_pix [0:8];
    logic [8:0]         diff_flags;

    filter_regs regs_i (
        .pclk_act, .reset_n, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i,
        .wb_dat_o, .wb_ack_o, .mode_o(mode), .strength_o(strength)
    );

    pixel_window window_i (
        .pclk_act, .reset_n, .prev_i, .curr_i, .next_i, .col_i, .window_o(window)
    );

    edge_scaler scaler_i (
        .pclk_act, .reset_n, .window_i(window), .strength_i(strength), .sub_o(sub_pix)
    );

    diff_map diff_i (
        .pclk_act, .reset_n, .window_i(window), .diff_o(diff_flags)
    );

    output_stage out_i (
        .pclk_act, .reset_n, .mode_i(mode), .center_i(window[`WIN_E]), .sub_i(sub_pix),
        .diff_i(diff_flags), .row_i, .col_i, .hsync_i, .vsync_i, .de_i, .mask_en_i,
        .line_id_i, .col_id_i, .data_o, .hsync_o, .vsync_o, .de_o, .mask_en_o,
        .line_id_o, .col_id_o
    );

endmodule

// ==== verilog/output_stage.sv ====
// side-signal and centre-pixel delay line with the final output mode mux
`timescale 1ns/1ps
`include "filter_settings.svh"

module output_stage (
    input  logic               pclk_act,
    input  logic               reset_n,
    input  logic [1:0]         mode_i,
    input  filter_pkg::pixel_t center_i,
    input  filter_pkg::pixel_t sub_i [0:8],
    input  logic [8:0]         diff_i,
    input  logic [2:0]         row_i,
    input  logic [2:0]         col_i,
    input  logic               hsync_i,
    input  logic               vsync_i,
    input  logic               de_i,
    input  logic               mask_en_i,
    input  logic [2:0]         line_id_i,
    input  logic [2:0]         col_id_i,
    output filter_pkg::pixel_t data_o,
    output logic               hsync_o,
    output logic               vsync_o,
    output logic               de_o,
    output logic               mask_en_o,
    output logic [2:0]         line_id_o,
    output logic [2:0]         col_id_o
);

    // syncs, enables, row, col, ids and the centre word in one vector
    localparam int SIDE_W = 16 + `PIX_W;

    logic [SIDE_W-1:0] side_pipe [`FILTER_STAGES];
    logic              hsync_d, vsync_d, de_d, mask_en_d;
    logic [2:0]        row_d, col_d, line_id_d, col_id_d;
    filter_pkg::pixel_t center_d;
    logic [3:0]        sub_idx;
    logic              in_range;
    filter_pkg::pixel_t data_nxt;

    always_ff @(posedge pclk_act or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `FILTER_STAGES; i++) begin
                side_pipe[i] <= '0;
            end
        end else begin
            side_pipe[0] <= {hsync_i, vsync_i, de_i, mask_en_i, row_i, col_i,
                             line_id_i, col_id_i, center_i.raw};
            for (int i = 1; i < `FILTER_STAGES; i++) begin
                side_pipe[i] <= side_pipe[i-1];
            end
        end
    end

    assign {hsync_d, vsync_d, de_d, mask_en_d, row_d, col_d, line_id_d, col_id_d,
            center_d.raw} = side_pipe[`FILTER_STAGES-1];

    assign in_range = (row_d < 3'd3) && (col_d < 3'd3);
    assign sub_idx  = {2'b00, row_d[1:0]} * 4'd3 + {2'b00, col_d[1:0]};

    always_comb begin
        case (mode_i)
            `MODE_PASS:  data_nxt = center_d;
            `MODE_SCALE: data_nxt = in_range ? sub_i[sub_idx] : center_d;
            `MODE_DIFF: begin
                if (in_range && diff_i[sub_idx]) begin
                    data_nxt.raw = `COLOR_DIFF;
                end else begin
                    data_nxt.raw = `COLOR_SAME;
                end
            end
            // mode 2 has no filter behind it
            default:     data_nxt = center_d;
        endcase
    end

    always_ff @(posedge pclk_act or negedge reset_n) begin
        if (!reset_n) begin
            data_o    <= '0;
            hsync_o   <= 1'b0;
            vsync_o   <= 1'b0;
            de_o      <= 1'b0;
            mask_en_o <= 1'b0;
            line_id_o <= '0;
            col_id_o  <= '0;
        end else begin
            data_o    <= data_nxt;
            hsync_o   <= hsync_d;
            vsync_o   <= vsync_d;
            de_o      <= de_d;
            mask_en_o <= mask_en_d;
            line_id_o <= line_id_d;
            col_id_o  <= col_id_d;
        end
    end

endmodule

// ==== verilog/diff_map.sv ====
// yuv-approximate difference flags of the centre against every window pixel
`timescale 1ns/1ps
`include "filter_settings.svh"

module diff_map (
    input  logic               pclk_act,
    input  logic               reset_n,
    input  filter_pkg::pixel_t window_i [0:8],
    output logic [8:0]         diff_o
);

    // half-widths of the "same colour" window
    localparam logic signed [9:0] Y_LIM = 10'sd24;
    localparam logic signed [9:0] U_LIM = 10'sd4;
    localparam logic signed [9:0] V_LIM = 10'sd6;

    // only the top six bits of each channel count
    function automatic logic pixel_diff(filter_pkg::pixel_t a, filter_pkg::pixel_t b);
        logic signed [9:0] dr, db, dg;
        logic signed [9:0] t, y, u, v;
        dr = $signed({4'b0, a.ch.r[`CH_W-1:2]}) - $signed({4'b0, b.ch.r[`CH_W-1:2]});
        db = $signed({4'b0, a.ch.b[`CH_W-1:2]}) - $signed({4'b0, b.ch.b[`CH_W-1:2]});
        dg = $signed({4'b0, a.ch.g[`CH_W-1:2]}) - $signed({4'b0, b.ch.g[`CH_W-1:2]});
        t = dr + db;
        y = t + dg;
        u = dr - db;
        v = (dg <<< 1) - t;
        return !((y > -Y_LIM) && (y < Y_LIM) &&
                 (u > -U_LIM) && (u < U_LIM) &&
                 (v > -V_LIM) && (v < V_LIM));
    endfunction

    logic [8:0] flags;
    logic [8:0] diff_pipe [`FILTER_STAGES];

    always_comb begin
        for (int k = 0; k < 9; k++) begin
            flags[k] = pixel_diff(window_i[`WIN_E], window_i[k]);
        end
    end

    // computed at stage 1, carried along to stage 4
    always_ff @(posedge pclk_act or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `FILTER_STAGES; i++) begin
                diff_pipe[i] <= '0;
            end
        end else begin
            diff_pipe[0] <= flags;
            for (int i = 1; i < `FILTER_STAGES; i++) begin
                diff_pipe[i] <= diff_pipe[i-1];
            end
        end
    end

    assign diff_o = diff_pipe[`FILTER_STAGES-1];

endmodule

// ==== verilog/edge_scaler.sv ====
// edge-directed 3x scaler, similarity compares, corner selection and strength blends
`timescale 1ns/1ps
`include "filter_settings.svh"

module edge_scaler (
    input  logic               pclk_act,
    input  logic               reset_n,
    input  filter_pkg::pixel_t window_i [0:8],
    input  logic [2:0]         strength_i,
    output filter_pkg::pixel_t sub_o [0:8]
);

    // true when every channel is closer than CMP_DELTA
    function automatic logic similar(filter_pkg::pixel_t a, filter_pkg::pixel_t b);
        logic [`CH_W-1:0] dr;
        logic [`CH_W-1:0] db;
        logic [`CH_W-1:0] dg;
        dr = (a.ch.r >= b.ch.r) ? a.ch.r - b.ch.r : b.ch.r - a.ch.r;
        db = (a.ch.b >= b.ch.b) ? a.ch.b - b.ch.b : b.ch.b - a.ch.b;
        dg = (a.ch.g >= b.ch.g) ? a.ch.g - b.ch.g : b.ch.g - a.ch.g;
        return (dr < `CMP_DELTA) && (db < `CMP_DELTA) && (dg < `CMP_DELTA);
    endfunction

    // shift-sum weights, mask bits select a/2 a/4 a/8 b/2 b/4 b/8
    function automatic logic [`CH_W-1:0] blend_ch(logic [`CH_W-1:0] a,
                                                  logic [`CH_W-1:0] b,
                                                  logic [2:0] s);
        logic [5:0] w;
        case (s)
            3'd0:    w = 6'b111_001;
            3'd1:    w = 6'b110_010;
            3'd2:    w = 6'b101_011;
            3'd3:    w = 6'b100_100;
            3'd4:    w = 6'b011_101;
            3'd5:    w = 6'b010_110;
            default: w = 6'b001_111;
        endcase
        // full strength takes the neighbour as is
        if (s == 3'd7) begin
            return b;
        end
        return (w[5] ? a >> 1 : '0) + (w[4] ? a >> 2 : '0) + (w[3] ? a >> 3 : '0)
             + (w[2] ? b >> 1 : '0) + (w[1] ? b >> 2 : '0) + (w[0] ? b >> 3 : '0);
    endfunction

    function automatic filter_pkg::pixel_t blend(filter_pkg::pixel_t e,
                                                 filter_pkg::pixel_t n,
                                                 logic [2:0] s);
        filter_pkg::pixel_t res;
        res.ch.r = blend_ch(e.ch.r, n.ch.r, s);
        res.ch.b = blend_ch(e.ch.b, n.ch.b, s);
        res.ch.g = blend_ch(e.ch.g, n.ch.g, s);
        return res;
    endfunction

    // stage 1, compares
    logic cond_f1;
    logic db_f1, bf_f1, dh_f1, hf_f1;
    logic ea_f1, ec_f1, eg_f1, ei_f1;
    filter_pkg::pixel_t e_f1, b_f1, d_f1, f_f1, h_f1;
    // stage 2, selections and blends
    logic [8:0] sel_f2;
    filter_pkg::pixel_t e_f2, bl_b_f2, bl_d_f2, bl_f_f2, bl_h_f2;
    filter_pkg::pixel_t src [0:8];
    // stages 3 and 4
    filter_pkg::pixel_t sub_f3 [0:8];
    filter_pkg::pixel_t sub_f4 [0:8];

    // blend source per sub-pixel, corners lean on D or F
    always_comb begin
        src[0] = bl_d_f2;
        src[1] = bl_b_f2;
        src[2] = bl_f_f2;
        src[3] = bl_d_f2;
        src[5] = bl_f_f2;
        src[6] = bl_d_f2;
        src[7] = bl_h_f2;
        src[8] = bl_f_f2;
    end

    always_ff @(posedge pclk_act or negedge reset_n) begin
        if (!reset_n) begin
            cond_f1 <= 1'b0;
            {db_f1, bf_f1, dh_f1, hf_f1} <= '0;
            {ea_f1, ec_f1, eg_f1, ei_f1} <= '0;
            {e_f1, b_f1, d_f1, f_f1, h_f1} <= '0;
            sel_f2 <= '0;
            {e_f2, bl_b_f2, bl_d_f2, bl_f_f2, bl_h_f2} <= '0;
            for (int k = 0; k < 9; k++) begin
                sub_f3[k] <= '0;
                sub_f4[k] <= '0;
            end
        end else begin
            // no edge unless both cross pairs differ
            cond_f1 <= !similar(window_i[`WIN_B], window_i[`WIN_H]) &&
                       !similar(window_i[`WIN_D], window_i[`WIN_F]);
            db_f1 <= similar(window_i[`WIN_D], window_i[`WIN_B]);
            bf_f1 <= similar(window_i[`WIN_B], window_i[`WIN_F]);
            dh_f1 <= similar(window_i[`WIN_D], window_i[`WIN_H]);
            hf_f1 <= similar(window_i[`WIN_H], window_i[`WIN_F]);
            ea_f1 <= !similar(window_i[`WIN_E], window_i[`WIN_A]);
            ec_f1 <= !similar(window_i[`WIN_E], window_i[`WIN_C]);
            eg_f1 <= !similar(window_i[`WIN_E], window_i[`WIN_G]);
            ei_f1 <= !similar(window_i[`WIN_E], window_i[`WIN_I]);
            e_f1 <= window_i[`WIN_E];
            b_f1 <= window_i[`WIN_B];
            d_f1 <= window_i[`WIN_D];
            f_f1 <= window_i[`WIN_F];
            h_f1 <= window_i[`WIN_H];

            sel_f2[0] <= db_f1 && cond_f1;
            sel_f2[1] <= ((db_f1 && ec_f1) || (bf_f1 && ea_f1)) && cond_f1;
            sel_f2[2] <= bf_f1 && cond_f1;
            sel_f2[3] <= ((db_f1 && eg_f1) || (dh_f1 && ea_f1)) && cond_f1;
            sel_f2[5] <= ((bf_f1 && ei_f1) || (hf_f1 && ec_f1)) && cond_f1;
            sel_f2[6] <= dh_f1 && cond_f1;
            sel_f2[7] <= ((dh_f1 && ei_f1) || (hf_f1 && eg_f1)) && cond_f1;
            sel_f2[8] <= hf_f1 && cond_f1;
            e_f2    <= e_f1;
            bl_b_f2 <= blend(e_f1, b_f1, strength_i);
            bl_d_f2 <= blend(e_f1, d_f1, strength_i);
            bl_f_f2 <= blend(e_f1, f_f1, strength_i);
            bl_h_f2 <= blend(e_f1, h_f1, strength_i);

            for (int k = 0; k < 9; k++) begin
                if (k == `WIN_E) begin
                    // the middle sub-pixel is never blended
                    sub_f3[k] <= e_f2;
                end else begin
                    sub_f3[k] <= sel_f2[k] ? src[k] : e_f2;
                end
                sub_f4[k] <= sub_f3[k];
            end
        end
    end

    assign sub_o = sub_f4;

endmodule

// ==== verilog/pixel_window.sv ====
// line history registers forming the 3x3 neighbourhood around the centre pixel
`timescale 1ns/1ps
`include "filter_settings.svh"

module pixel_window (
    input  logic               pclk_act,
    input  logic               reset_n,
    input  filter_pkg::pixel_t prev_i,
    input  filter_pkg::pixel_t curr_i,
    input  filter_pkg::pixel_t next_i,
    input  logic [2:0]         col_i,
    output filter_pkg::pixel_t window_o [0:8]
);

    // m1 is one source pixel back, m2 is two back
    filter_pkg::pixel_t prev_m1, prev_m2;
    filter_pkg::pixel_t curr_m1, curr_m2;
    filter_pkg::pixel_t next_m1, next_m2;

    // each source pixel is repeated three times, advance on the last copy
    always_ff @(posedge pclk_act or negedge reset_n) begin
        if (!reset_n) begin
            prev_m1 <= '0;
            prev_m2 <= '0;
            curr_m1 <= '0;
            curr_m2 <= '0;
            next_m1 <= '0;
            next_m2 <= '0;
        end else if (col_i == 3'd2) begin
            prev_m2 <= prev_m1;
            prev_m1 <= prev_i;
            curr_m2 <= curr_m1;
            curr_m1 <= curr_i;
            next_m2 <= next_m1;
            next_m1 <= next_i;
        end
    end

    always_comb begin
        window_o[`WIN_A] = prev_m2;
        window_o[`WIN_B] = prev_m1;
        window_o[`WIN_C] = prev_i;
        window_o[`WIN_D] = curr_m2;
        window_o[`WIN_E] = curr_m1;
        window_o[`WIN_F] = curr_i;
        window_o[`WIN_G] = next_m2;
        window_o[`WIN_H] = next_m1;
        window_o[`WIN_I] = next_i;
    end

endmodule

// ==== verilog/filter_regs.sv ====
// wishbone classic slave with the filter mode and strength registers
`timescale 1ns/1ps
`include "filter_settings.svh"

module filter_regs (
    input  logic                  pclk_act,
    input  logic                  reset_n,
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  logic [`WB_ADDR_W-1:0] wb_adr_i,
    input  logic [`WB_DATA_W-1:0] wb_dat_i,
    output logic [`WB_DATA_W-1:0] wb_dat_o,
    output logic                  wb_ack_o,
    output logic [1:0]            mode_o,
    output logic [2:0]            strength_o
);

    logic                  req;
    logic [`WB_DATA_W-1:0] rd_data;

    // a request is served once, ack drops the cycle after
    assign req = wb_cyc_i && wb_stb_i && !wb_ack_o;

    always_comb begin
        rd_data = '0;
        case (wb_adr_i)
            `REG_MODE:     rd_data[1:0] = mode_o;
            `REG_STRENGTH: rd_data[2:0] = strength_o;
            // unmapped addresses read back zero
            default:       rd_data = '0;
        endcase
    end

    always_ff @(posedge pclk_act or negedge reset_n) begin
        if (!reset_n) begin
            wb_ack_o   <= 1'b0;
            wb_dat_o   <= '0;
            mode_o     <= '0;
            strength_o <= '0;
        end else begin
            wb_ack_o <= req;
            if (req) begin
                wb_dat_o <= rd_data;
            end
            if (req && wb_we_i) begin
                if (wb_adr_i == `REG_MODE) begin
                    mode_o <= wb_dat_i[1:0];
                end
                if (wb_adr_i == `REG_STRENGTH) begin
                    strength_o <= wb_dat_i[2:0];
                end
            end
        end
    end

endmodule

// ==== verilog/filter_pkg.sv ====
// shared pixel type, one video word seen raw or as three colour channels
`include "filter_settings.svh"

package filter_pkg;

    // channel order is the one the video path uses
    // red on top, blue in the middle, green at the bottom
    typedef union packed {
        logic [`PIX_W-1:0] raw;
        struct packed {
            logic [`CH_W-1:0] r;
            logic [`CH_W-1:0] b;
            logic [`CH_W-1:0] g;
        } ch;
    } pixel_t;

endpackage

// ==== include/filter_settings.svh ====
// pixel and channel widths, window positions, pipeline depth, mode codes, bus widths, colours
`ifndef FILTER_SETTINGS_SVH
`define FILTER_SETTINGS_SVH

`define PIX_W           24
`define CH_W            8

// 3x3 neighbourhood, row-major, E is the centre
`define WIN_A           0
`define WIN_B           1
`define WIN_C           2
`define WIN_D           3
`define WIN_E           4
`define WIN_F           5
`define WIN_G           6
`define WIN_H           7
`define WIN_I           8

`define FILTER_STAGES   4

`define MODE_PASS       0
`define MODE_SCALE      1
`define MODE_DIFF       3

`define WB_ADDR_W       2
`define WB_DATA_W       8
`define REG_MODE        0
`define REG_STRENGTH    1

// per-channel similarity limit
`define CMP_DELTA       32

`define COLOR_SAME      24'h00FF00
`define COLOR_DIFF      24'hFF0000

`endif
